//--- video_gen.f
source/video_pkg.sv
source/video_timing.sv
source/video_regs.sv
source/text_fetch.sv
source/pixel_shifter.sv
source/video_gen.sv
verif/video_gen_checker.sv
verif/video_gen_tb.sv

//--- Bender.yml
package:
  name: video_gen

sources:
  - source/video_pkg.sv
  - source/video_timing.sv
  - source/video_regs.sv
  - source/text_fetch.sv
  - source/pixel_shifter.sv
  - source/video_gen.sv
  - target: test
    files:
      - verif/video_gen_checker.sv
      - verif/video_gen_tb.sv

//--- verif/video_gen_tb.sv
// testbench for the text mode video generator
// lfsr filled vram and font ram, reference pixel model, sync and register checks
module video_gen_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import video_pkg::*;

    localparam int frame_cycles = int'(total_width) * int'(total_height);
    localparam int wait_limit   = 3 * frame_cycles;    // any single wait
    localparam int frame_pixels = int'(visible_width) * int'(visible_height);

    logic        clk;
    logic        reset_i;
    logic        enable_i;
    logic        reg_wr_i;
    logic [2:0]  reg_num_i;
    logic [15:0] reg_data_i;
    logic [15:0] vram_data_i;
    logic [7:0]  fontram_data_i;
    logic        vram_sel_o;
    vaddr_t      vram_addr_o;
    logic        fontram_sel_o;
    faddr_t      fontram_addr_o;
    pal_t        pal_index_o;
    logic        hsync_o;
    logic        vsync_o;
    logic        dv_de_o;

    logic [15:0] vram [0:65535];
    logic [7:0]  font [0:8191];
    logic [31:0] lfsr_q;

    vaddr_t     sh_start;       // register values as last written
    vaddr_t     sh_width;
    logic [3:0] sh_height;
    logic [4:0] sh_bank;
    vaddr_t     fr_start;       // values in force for the current frame
    vaddr_t     fr_width;
    logic [3:0] fr_height;
    logic [4:0] fr_bank;

    int   errors;
    int   checks;
    int   pixel_checks;
    int   tests_passed;
    int   tests_failed;
    int   line_q;               // visible line of the monitor
    int   pix_col;
    int   vsel_col;
    int   fsel_col;
    logic vs_active_q;
    logic de_q;

    video_gen dut_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .enable_i       (enable_i),
        .reg_wr_i       (reg_wr_i),
        .reg_num_i      (reg_num_i),
        .reg_data_i     (reg_data_i),
        .vram_data_i    (vram_data_i),
        .fontram_data_i (fontram_data_i),
        .vram_sel_o     (vram_sel_o),
        .vram_addr_o    (vram_addr_o),
        .fontram_sel_o  (fontram_sel_o),
        .fontram_addr_o (fontram_addr_o),
        .pal_index_o    (pal_index_o),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o),
        .dv_de_o        (dv_de_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns pixel clock
    end

    // one cycle synchronous memories
    always @(posedge clk) begin
        if (vram_sel_o) vram_data_i <= vram[vram_addr_o];
        if (fontram_sel_o) fontram_data_i <= font[fontram_addr_o];
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic vaddr_t tile_address(input int line, input int col);
        int group;
        group = line / (int'(fr_height) + 1);  // tile line of this pixel line
        return vaddr_t'(fr_start + vaddr_t'(group) * fr_width + vaddr_t'(col));
    endfunction

    function automatic faddr_t font_address(input logic [15:0] word, input int line);
        logic [3:0]  row;
        logic [15:0] full;
        row = 4'(line % (int'(fr_height) + 1));
        if (fr_height[3]) full = {fr_bank[4:1], word[7:0], row};       // 16 line font
        else full = {fr_bank, word[7:0], row[2:0]};
        return full[12:0];
    endfunction

    function automatic pal_t expected_pixel(input int line, input int col);
        logic [15:0] word;
        logic [7:0]  pattern;
        word = vram[tile_address(line, col / int'(tile_width))];
        pattern = font[font_address(word, line)];
        return pattern[7 - (col % 8)] ? word[11:8] : word[15:12];     // fg : bg
    endfunction

    task automatic check_int(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("FAIL t=%0t: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout: no %s within %0d cycles", what, wait_limit);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    // reference model follows every select and every visible pixel
    always @(negedge clk) begin
        if (reset_i) begin
            line_q = 0;
            pix_col = 0;
            vsel_col = 0;
            fsel_col = 0;
            vs_active_q = 1'b0;
            de_q = 1'b0;
            fr_start = '0;
            fr_width = tiles_wide;
            fr_height = 4'd7;
            fr_bank = '0;
        end else begin
            if ((vsync_o == v_sync_polarity) && !vs_active_q) begin
                fr_start = sh_start;        // writes of this frame apply to the next
                fr_width = sh_width;
                fr_height = sh_height;
                fr_bank = sh_bank;
                line_q = 0;
                pix_col = 0;
                vsel_col = 0;
                fsel_col = 0;
            end
            if (vram_sel_o) begin
                check_int($sformatf("vram_addr_o line %0d tile %0d", line_q, vsel_col),
                          vram_addr_o, tile_address(line_q, vsel_col));
                vsel_col++;
            end
            if (fontram_sel_o) begin
                check_int($sformatf("fontram_addr_o line %0d tile %0d", line_q, fsel_col),
                          fontram_addr_o,
                          font_address(vram[tile_address(line_q, fsel_col)], line_q));
                fsel_col++;
            end
            if (dv_de_o) begin
                check_int($sformatf("pal_index_o line %0d pixel %0d", line_q, pix_col),
                          pal_index_o, expected_pixel(line_q, pix_col));
                pixel_checks++;
                pix_col++;
            end else if (de_q) begin
                line_q++;       // line done, fetch of the next one follows
                pix_col = 0;
                vsel_col = 0;
                fsel_col = 0;
            end
            vs_active_q = (vsync_o == v_sync_polarity);
            de_q = dv_de_o;
        end
    end

    // returns on the first cycle of the next vsync pulse
    task automatic wait_vsync(output int de_cycles, output int sel_cycles);
        int   n;
        logic vs_d;
        logic started;
        n = 0;
        de_cycles = 0;
        sel_cycles = 0;
        @(negedge clk);
        vs_d = vsync_o;
        started = 1'b0;
        while (!started) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) abort_on_timeout("vsync pulse");
            de_cycles += dv_de_o;
            sel_cycles += (vram_sel_o || fontram_sel_o);
            started = (vsync_o == v_sync_polarity) && (vs_d != v_sync_polarity);
            vs_d = vsync_o;
        end
    endtask

    task automatic wait_output_high(input int which, input string name);
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) abort_on_timeout(name);
            case (which)
                0: seen = vram_sel_o;
                1: seen = fontram_sel_o;
                default: seen = dv_de_o;
            endcase
        end
    endtask

    // from a vsync start to a random point in the visible lines
    task automatic move_to_mid_frame();
        int n;
        n = int'(v_sync_pulse + v_back_porch + 11'd1) * int'(total_width);
        n += int'(rand_bits(10));
        repeat (n) @(posedge clk);
    endtask

    task automatic write_reg(input logic [2:0] num, input logic [15:0] data);
        @(posedge clk);
        reg_wr_i <= 1'b1;
        reg_num_i <= num;
        reg_data_i <= data;
        @(posedge clk);
        reg_wr_i <= 1'b0;
        case (num)
            reg_dispstart: sh_start = data;
            reg_tilewidth: sh_width = data;
            reg_fontctrl: begin
                sh_height = data[3:0];
                sh_bank = data[15:11];
            end
            default: ;  // no register behind other numbers
        endcase
    endtask

    // one frame between vsync starts, measured at the pins
    task automatic check_sync_timing();
        int   de_cycles;
        int   sel_cycles;
        int   cycles;
        int   h_low;
        int   last_fall;
        int   de_run;
        int   de_lines;
        int   v_low;
        logic hs_d;
        logic vs_d;
        logic de_d;
        logic done;
        wait_vsync(de_cycles, sel_cycles);
        cycles = 0;
        h_low = 0;
        last_fall = -1;
        de_run = 0;
        de_lines = 0;
        v_low = 1;
        hs_d = hsync_o;
        vs_d = vsync_o;
        de_d = dv_de_o;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit) abort_on_timeout("end of frame");
            done = (vsync_o == v_sync_polarity) && (vs_d != v_sync_polarity);
            if (!done && (vsync_o == v_sync_polarity)) v_low++;
            if (hsync_o == h_sync_polarity) begin
                if ((hs_d != h_sync_polarity) && (last_fall >= 0)) begin
                    check_int("hsync_o period", cycles - last_fall, int'(total_width));
                end
                if (hs_d != h_sync_polarity) last_fall = cycles;
                h_low++;
            end else if (hs_d == h_sync_polarity) begin
                check_int("hsync_o pulse width", h_low, int'(h_sync_pulse));
                h_low = 0;
            end
            if (dv_de_o) begin
                de_run++;
            end else if (de_d) begin
                check_int("dv_de_o cycles per line", de_run, int'(visible_width));
                de_lines++;
                de_run = 0;
            end
            hs_d = hsync_o;
            vs_d = vsync_o;
            de_d = dv_de_o;
        end
        check_int("frame length", cycles, frame_cycles);
        check_int("vsync_o active cycles", v_low, int'(v_sync_pulse) * int'(total_width));
        check_int("dv_de_o lines per frame", de_lines, int'(visible_height));
    endtask

    task automatic finish_test(input string name, input int err_mark);
        if (errors == err_mark) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_mark);
        end
    endtask

    initial begin
        int          de_cycles;
        int          sel_cycles;
        int          err_mark;
        int          pix_mark;
        int          assert_fails;
        vaddr_t      new_start;
        vaddr_t      new_width;
        logic [4:0]  bank;
        logic [15:0] full;
        reset_i = 1'b1;
        enable_i = 1'b0;
        reg_wr_i = 1'b0;
        reg_num_i = '0;
        reg_data_i = '0;
        vram_data_i = '0;
        fontram_data_i = '0;
        sh_start = '0;
        sh_width = tiles_wide;
        sh_height = 4'd7;
        sh_bank = '0;
        errors = 0;
        checks = 0;
        pixel_checks = 0;
        tests_passed = 0;
        tests_failed = 0;
        lfsr_q = 32'h25e02db1;
        for (int a = 0; a < 65536; a++) vram[a] = 16'(rand_bits(16));
        for (int a = 0; a < 8192; a++) font[a] = 8'(rand_bits(8));

        // reset, then display stays off until a frame end sees enable_i
        err_mark = errors;
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_int("vram_sel_o in reset", vram_sel_o, 0);
        check_int("fontram_sel_o in reset", fontram_sel_o, 0);
        check_int("dv_de_o in reset", dv_de_o, 0);
        check_int("hsync_o in reset", hsync_o, !h_sync_polarity);
        check_int("vsync_o in reset", vsync_o, !v_sync_polarity);
        check_int("pal_index_o in reset", pal_index_o, 0);
        @(posedge clk);
        reset_i <= 1'b0;
        wait_vsync(de_cycles, sel_cycles);
        check_int("dv_de_o cycles, first frame", de_cycles, 0);
        wait_vsync(de_cycles, sel_cycles);
        check_int("dv_de_o cycles, disabled frame", de_cycles, 0);
        check_int("select cycles, disabled frame", sel_cycles, 0);
        move_to_mid_frame();
        enable_i <= 1'b1;
        wait_vsync(de_cycles, sel_cycles);
        check_int("dv_de_o cycles after mid frame enable", de_cycles, 0);
        check_int("select cycles after mid frame enable", sel_cycles, 0);
        wait_output_high(2, "dv_de_o after enable");
        finish_test("1 reset and enable", err_mark);

        err_mark = errors;
        check_sync_timing();
        finish_test("2 sync timing", err_mark);

        err_mark = errors;
        wait_vsync(de_cycles, sel_cycles);
        pix_mark = pixel_checks;
        wait_vsync(de_cycles, sel_cycles);
        wait_vsync(de_cycles, sel_cycles);
        check_int("pixels compared over two frames", pixel_checks - pix_mark, 2 * frame_pixels);
        finish_test("3 pixel content", err_mark);

        // the monitor keeps the old values until the frame ends
        err_mark = errors;
        new_start = vaddr_t'(rand_bits(16));
        new_width = vaddr_t'(rand_bits(6)) + 16'd1;
        move_to_mid_frame();
        write_reg(reg_dispstart, new_start);
        write_reg(reg_tilewidth, new_width);
        write_reg(3'(3 + rand_bits(2)), 16'(rand_bits(16)));   // unused number
        wait_vsync(de_cycles, sel_cycles);
        wait_output_high(0, "vram_sel_o in new frame");
        check_int("first vram_addr_o after start write", vram_addr_o, new_start);
        wait_vsync(de_cycles, sel_cycles);
        finish_test("4 register effects", err_mark);

        err_mark = errors;
        bank = 5'(rand_bits(5)) | 5'b00010;    // bit 1 survives the 13 bit address
        move_to_mid_frame();
        write_reg(reg_fontctrl, {bank, 7'd0, 4'hf});
        wait_vsync(de_cycles, sel_cycles);
        wait_output_high(1, "fontram_sel_o in new frame");
        full = {bank[4:1], vram[sh_start][7:0], 4'd0};
        check_int("first fontram_addr_o with 16 line font", fontram_addr_o, full[12:0]);
        wait_vsync(de_cycles, sel_cycles);
        finish_test("5 font control", err_mark);

        assert_fails = dut_i.checker_i.blank_fails + dut_i.checker_i.follow_fails
                       + dut_i.checker_i.hsync_fails;
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_passed, tests_failed, checks, errors, assert_fails);
        if ((errors == 0) && (tests_failed == 0) && (assert_fails == 0)) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- verif/video_gen_checker.sv
// video generator bound checks
// selects during vertical blanking, font select spacing and hsync pulse width
module video_gen_checker (
    input logic clk,
    input logic reset_i,
    input logic dv_de_o,
    input logic hsync_o,
    input logic vram_sel_o,
    input logic fontram_sel_o,
    input logic frame_end_i     // internal frame pulse of the top level
);
    timeunit 1ns;
    timeprecision 100ps;
    import video_pkg::*;

    int unsigned idle_count;        // cycles since dv_de_o or frame end
    int unsigned blank_fails = 0;
    int unsigned follow_fails = 0;
    int unsigned hsync_fails = 0;

    // a full line without dv_de_o only happens in vertical blanking
    always_ff @(posedge clk) begin
        if (reset_i) begin
            idle_count <= 0;
        end else if (dv_de_o || frame_end_i) begin
            idle_count <= 0;
        end else if (idle_count < total_width) begin
            idle_count <= idle_count + 1;
        end
    end

    blank_select_a: assert property (@(posedge clk) disable iff (reset_i)
        (idle_count >= total_width) |-> (!vram_sel_o && !fontram_sel_o))
        else begin
            $error("memory select during vertical blanking");
            blank_fails++;
        end

    // font read always two cycles behind its tile read
    font_follow_a: assert property (@(posedge clk) disable iff (reset_i)
        fontram_sel_o == $past(vram_sel_o, 2))
        else begin
            $error("fontram_sel_o not two cycles after vram_sel_o");
            follow_fails++;
        end

    hsync_width_a: assert property (@(posedge clk) disable iff (reset_i)
        ($changed(hsync_o) && (hsync_o == h_sync_polarity)) |->
            (hsync_o == h_sync_polarity) [*h_sync_pulse] ##1 (hsync_o != h_sync_polarity))
        else begin
            $error("hsync pulse width wrong");
            hsync_fails++;
        end

endmodule

bind video_gen video_gen_checker checker_i (
    .clk           (clk),
    .reset_i       (reset_i),
    .dv_de_o       (dv_de_o),
    .hsync_o       (hsync_o),
    .vram_sel_o    (vram_sel_o),
    .fontram_sel_o (fontram_sel_o),
    .frame_end_i   (frame_end)
);

//--- source/video_gen.sv
// text mode video generator top
// sync timing, config registers, tile/font fetch and pixel shifter
module video_gen (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                enable_i,
    input  logic                reg_wr_i,
    input  logic [2:0]          reg_num_i,
    input  logic [15:0]         reg_data_i,
    input  logic [15:0]         vram_data_i,
    input  logic [7:0]          fontram_data_i,
    output logic                vram_sel_o,
    output video_pkg::vaddr_t   vram_addr_o,
    output logic                fontram_sel_o,
    output video_pkg::faddr_t   fontram_addr_o,
    output video_pkg::pal_t     pal_index_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o
);
    import video_pkg::*;

    logic       fetch;
    logic       line_end;
    logic       frame_end;
    logic       display_en;
    vaddr_t     text_start;
    vaddr_t     line_width;
    logic [3:0] font_height;
    logic [4:0] font_bank;
    logic       load;
    logic [7:0] font_byte;
    logic [7:0] attr;

    video_timing timing_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .enable_i     (enable_i),
        .hsync_o      (hsync_o),
        .vsync_o      (vsync_o),
        .dv_de_o      (dv_de_o),
        .fetch_o      (fetch),
        .line_end_o   (line_end),
        .frame_end_o  (frame_end),
        .display_en_o (display_en)
    );

    video_regs regs_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .reg_wr_i      (reg_wr_i),
        .reg_num_i     (reg_num_i),
        .reg_data_i    (reg_data_i),
        .text_start_o  (text_start),
        .line_width_o  (line_width),
        .font_height_o (font_height),
        .font_bank_o   (font_bank)
    );

    text_fetch fetch_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .fetch_i        (fetch),
        .line_end_i     (line_end),
        .frame_end_i    (frame_end),
        .display_en_i   (display_en),
        .text_start_i   (text_start),
        .line_width_i   (line_width),
        .font_height_i  (font_height),
        .font_bank_i    (font_bank),
        .vram_data_i    (vram_data_i),
        .fontram_data_i (fontram_data_i),
        .vram_sel_o     (vram_sel_o),
        .vram_addr_o    (vram_addr_o),
        .fontram_sel_o  (fontram_sel_o),
        .fontram_addr_o (fontram_addr_o),
        .load_o         (load),
        .font_byte_o    (font_byte),
        .attr_o         (attr)
    );

    pixel_shifter shifter_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .load_i      (load),
        .font_byte_i (font_byte),
        .attr_i      (attr),
        .pal_index_o (pal_index_o)
    );

endmodule

//--- source/pixel_shifter.sv
// font pixel shifter
// shifts a font byte out msb first and picks the foreground or background
// palette index from the tile attribute
module pixel_shifter (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              load_i,
    input  logic [7:0]        font_byte_i,
    input  logic [7:0]        attr_i,       // bg in high nibble, fg in low
    output video_pkg::pal_t   pal_index_o
);
    import video_pkg::*;

    logic [7:0] shift_q;
    logic [7:0] attr_q;
    logic [7:0] pixels;         // bits for this cycle, msb is current pixel
    logic [7:0] colors;
    pal_t       fore_color;
    pal_t       back_color;

    // a load feeds its first pixel straight through
    always_comb begin
        pixels     = load_i ? font_byte_i : shift_q;
        colors     = load_i ? attr_i : attr_q;
        fore_color = colors[3:0];
        back_color = colors[7:4];
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            shift_q     <= '0;
            attr_q      <= '0;
            pal_index_o <= '0;
        end else begin
            shift_q     <= {pixels[6:0], 1'b0};
            attr_q      <= colors;
            pal_index_o <= pixels[7] ? fore_color : back_color;
        end
    end

endmodule

//--- source/text_fetch.sv
// text tile fetch
// steps an 8 cycle tile phase during the fetch window, reads tile/attribute
// words from vram and font bytes from font ram, and tracks the text address
// and the font row of the current tile line
module text_fetch (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                fetch_i,
    input  logic                line_end_i,
    input  logic                frame_end_i,
    input  logic                display_en_i,
    input  video_pkg::vaddr_t   text_start_i,
    input  video_pkg::vaddr_t   line_width_i,
    input  logic [3:0]          font_height_i,
    input  logic [4:0]          font_bank_i,
    input  logic [15:0]         vram_data_i,
    input  logic [7:0]          fontram_data_i,
    output logic                vram_sel_o,
    output video_pkg::vaddr_t   vram_addr_o,
    output logic                fontram_sel_o,
    output video_pkg::faddr_t   fontram_addr_o,
    output logic                load_o,         // font byte ready for the shifter
    output logic [7:0]          font_byte_o,
    output logic [7:0]          attr_o
);
    import video_pkg::*;

    logic [2:0]  phase;             // tile phase, pixel rate
    vaddr_t      text_addr;         // next tile word
    vaddr_t      line_addr;         // first tile word of current tile line
    vaddr_t      next_line_addr;
    logic [3:0]  tile_row;          // font line within the tile
    vaddr_t      frame_width;       // register values held for the frame
    logic [3:0]  frame_height;
    logic [4:0]  frame_bank;
    logic [15:0] font_addr;         // full width, truncated on output
    logic [7:0]  attr_q;            // attribute of tile in flight

    always_comb begin
        next_line_addr = line_addr + frame_width;
        // 16 line fonts take one more row bit and one less bank bit
        if (frame_height[3]) begin
            font_addr = {frame_bank[4:1], vram_data_i[7:0], tile_row[3:0]};
        end else begin
            font_addr = {frame_bank[4:0], vram_data_i[7:0], tile_row[2:0]};
        end
    end

    // font data is valid two cycles after the font select
    assign load_o      = fetch_i && (phase == 3'd4);
    assign font_byte_o = fontram_data_i;
    assign attr_o      = attr_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            phase         <= '0;
            vram_sel_o    <= 1'b0;
            fontram_sel_o <= 1'b0;
            text_addr     <= '0;
            line_addr     <= '0;
            tile_row      <= '0;
            frame_width   <= tiles_wide;
            frame_height  <= 4'd7;
            frame_bank    <= '0;
        end else begin
            vram_sel_o    <= 1'b0;  // selects are single cycle
            fontram_sel_o <= 1'b0;
            phase         <= fetch_i ? phase + 3'd1 : 3'd0;

            if (fetch_i && (phase == 3'd0)) begin
                vram_sel_o <= display_en_i;     // tile and attribute word
                text_addr  <= text_addr + 16'd1;
            end
            if (fetch_i && (phase == 3'd2)) begin
                fontram_sel_o <= display_en_i;  // font line of that tile
            end

            if (frame_end_i) begin
                // register writes take effect here
                text_addr    <= text_start_i;
                line_addr    <= text_start_i;
                tile_row     <= '0;
                frame_width  <= line_width_i;
                frame_height <= font_height_i;
                frame_bank   <= font_bank_i;
            end else if (line_end_i) begin
                if (tile_row == frame_height) begin
                    tile_row  <= '0;                // next tile line
                    line_addr <= next_line_addr;
                    text_addr <= next_line_addr;
                end else begin
                    tile_row  <= tile_row + 4'd1;
                    text_addr <= line_addr;         // same tiles again
                end
            end
        end
    end

    // addresses and attribute only matter alongside their select
    always_ff @(posedge clk) begin
        if (fetch_i && (phase == 3'd0)) begin
            vram_addr_o <= text_addr;
        end
        if (fetch_i && (phase == 3'd2)) begin
            fontram_addr_o <= font_addr[12:0];
            attr_q         <= vram_data_i[15:8];    // high byte is color
        end
    end

endmodule

//--- source/video_regs.sv
// video configuration registers
// display start address, tile line width and font control, written by strobe
module video_regs (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                reg_wr_i,       // write strobe
    input  logic [2:0]          reg_num_i,
    input  logic [15:0]         reg_data_i,
    output video_pkg::vaddr_t   text_start_o,   // first tile word of the frame
    output video_pkg::vaddr_t   line_width_o,   // words per tile line
    output logic [3:0]          font_height_o,  // font lines minus one
    output logic [4:0]          font_bank_o
);
    import video_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            text_start_o  <= '0;
            line_width_o  <= tiles_wide;    // one screen wide
            font_height_o <= 4'd7;          // 8 line font
            font_bank_o   <= '0;
        end else if (reg_wr_i) begin
            case (reg_num_i)
                reg_dispstart: begin
                    text_start_o <= reg_data_i;
                end
                reg_tilewidth: begin
                    line_width_o <= reg_data_i;
                end
                reg_fontctrl: begin
                    font_height_o <= reg_data_i[3:0];
                    font_bank_o   <= reg_data_i[15:11];
                end
                default: begin
                    // other numbers have no register
                end
            endcase
        end
    end

endmodule

//--- source/video_timing.sv
// video sync timing
// runs the h/v counters through the sync states and drives registered
// hsync, vsync, display enable, fetch window and line/frame pulses
module video_timing (
    input  logic clk,
    input  logic reset_i,
    input  logic enable_i,      // sampled at frame end only
    output logic hsync_o,
    output logic vsync_o,
    output logic dv_de_o,
    output logic fetch_o,       // tile fetch window of a visible line
    output logic line_end_o,
    output logic frame_end_o,
    output logic display_en_o
);
    import video_pkg::*;

    video_state_t h_state;
    video_state_t h_state_next;
    video_state_t v_state;
    video_state_t v_state_next;
    count_t       h_count;
    count_t       v_count;
    count_t       h_limit;          // last count of current h state
    count_t       v_limit;          // last line of current v state
    logic         h_last;           // last pixel of line
    logic         v_last;           // last pixel of frame

    // horizontal thresholds, offscreen first then visible
    always_comb begin
        case (h_state)
            pre_sync:  h_limit = h_front_porch - 11'd1;
            sync:      h_limit = h_front_porch + h_sync_pulse - 11'd1;
            post_sync: h_limit = offscreen_width - 11'd1;
            visible:   h_limit = total_width - 11'd1;
        endcase
    end

    // vertical thresholds, visible lines then blanking
    always_comb begin
        case (v_state)
            visible:   v_limit = visible_height - 11'd1;
            pre_sync:  v_limit = visible_height + v_front_porch - 11'd1;
            sync:      v_limit = visible_height + v_front_porch + v_sync_pulse - 11'd1;
            post_sync: v_limit = total_height - 11'd1;
        endcase
    end

    always_comb begin
        h_last       = (h_state == visible) && (h_count == h_limit);
        v_last       = h_last && (v_state == post_sync) && (v_count == v_limit);
        h_state_next = (h_count == h_limit) ? video_state_t'(h_state + 2'd1) : h_state;
        v_state_next = (h_last && (v_count == v_limit)) ?
                       video_state_t'(v_state + 2'd1) : v_state;   // post_sync wraps to visible
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state      <= pre_sync;
            v_state      <= visible;
            h_count      <= '0;
            v_count      <= '0;
            hsync_o      <= ~h_sync_polarity;   // idle level
            vsync_o      <= ~v_sync_polarity;
            dv_de_o      <= 1'b0;
            fetch_o      <= 1'b0;
            line_end_o   <= 1'b0;
            frame_end_o  <= 1'b0;
            display_en_o <= 1'b0;
        end else begin
            h_state <= h_state_next;
            v_state <= v_state_next;
            if (h_last) begin
                h_count <= '0;
                v_count <= v_last ? '0 : v_count + 11'd1;  // new line or new frame
            end else begin
                h_count <= h_count + 11'd1;
            end

            hsync_o     <= (h_state == sync) ? h_sync_polarity : ~h_sync_polarity;
            vsync_o     <= (v_state == sync) ? v_sync_polarity : ~v_sync_polarity;
            dv_de_o     <= display_en_o && (h_state == visible) && (v_state == visible);
            line_end_o  <= h_last;
            frame_end_o <= v_last;

            // window opens early enough to cover the fetch pipeline
            if ((v_state == visible) && (h_count == h_fetch_open)) begin
                fetch_o <= 1'b1;
            end else if (h_count == h_fetch_close) begin
                fetch_o <= 1'b0;    // no tile past the right edge
            end

            if (v_last) begin
                display_en_o <= enable_i;   // whole frames on or off
            end
        end
    end

endmodule

//--- source/video_pkg.sv
// video generator shared definitions
// small text mode timing, register numbers and common types
package video_pkg;

    typedef logic [10:0] count_t;   // horizontal and vertical counters
    typedef logic [15:0] vaddr_t;   // vram word address
    typedef logic [12:0] faddr_t;   // font ram byte address
    typedef logic [3:0]  pal_t;     // palette index

    // sync state sequence, same order for both axes
    typedef enum logic [1:0] {
        pre_sync  = 2'd0,
        sync      = 2'd1,
        post_sync = 2'd2,
        visible   = 2'd3
    } video_state_t;

    // horizontal timing in pixels, offscreen area sits left of the visible area
    localparam count_t visible_width   = 11'd64;
    localparam count_t h_front_porch   = 11'd4;
    localparam count_t h_sync_pulse    = 11'd8;
    localparam count_t h_back_porch    = 11'd12;
    localparam count_t total_width     = visible_width + h_front_porch + h_sync_pulse
                                         + h_back_porch;
    localparam count_t offscreen_width = total_width - visible_width;

    // vertical timing in lines, visible lines come first
    localparam count_t visible_height  = 11'd24;
    localparam count_t v_front_porch   = 11'd2;
    localparam count_t v_sync_pulse    = 11'd2;
    localparam count_t v_back_porch    = 11'd3;
    localparam count_t total_height    = visible_height + v_front_porch + v_sync_pulse
                                         + v_back_porch;

    localparam logic h_sync_polarity = 1'b0;    // active low hsync
    localparam logic v_sync_polarity = 1'b0;    // active low vsync

    // tiles and fetch window
    localparam count_t tile_width    = 11'd8;
    localparam vaddr_t tiles_wide    = vaddr_t'(visible_width / tile_width);
    localparam count_t fetch_lead    = 11'd4;     // vram select to first pixel
    localparam count_t h_fetch_open  = offscreen_width - fetch_lead - 11'd1;
    localparam count_t h_fetch_close = total_width - fetch_lead - 11'd1;

    // writable register numbers
    localparam logic [2:0] reg_dispstart = 3'd0;
    localparam logic [2:0] reg_tilewidth = 3'd1;
    localparam logic [2:0] reg_fontctrl  = 3'd2;

endpackage
